//--- mem_chip_bus_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Bus widths and divider bank settings for the memory chip
// Imported by every RTL module and by the testbench
////////////////////////////////////////////////////////////////////////////

package mem_chip_bus_pkg;

  // Wishbone slave port
  localparam int unsigned AddrWidth = 48;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned SelWidth = DataWidth / 8;

  // Upper address bits carry the chip identifier
  localparam int unsigned ChipIdWidth = 8;
  localparam int unsigned OffsetWidth = AddrWidth - ChipIdWidth;

  ////////////////////////////////////////////////////////////////////////////
  // Clock divider bank
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned NumDivs = 5;
  localparam int unsigned DivWidth = 8;

  // Register k sits in bits 8k+7 to 8k
  // SRAM clock divides by 4, the link clocks run undivided
  localparam logic [NumDivs*DivWidth-1:0] DivDefaults = {
    8'd1, 8'd1, 8'd1, 8'd1, 8'd4
  };

endpackage

//--- mem_chip_addr_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Local address map of the memory chip and the target select
// Offsets are relative to the chip identifier field
////////////////////////////////////////////////////////////////////////////

package mem_chip_addr_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // SRAM window
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [39:0] SramBase = 40'h00_8000_0000;
  localparam int unsigned SramWords = 256;
  localparam int unsigned SramIdxWidth = $clog2(SramWords);

  // Four bytes per word
  localparam logic [39:0] SramSpan = 40'(SramWords * 4);

  ////////////////////////////////////////////////////////////////////////////
  // Clock divider register window
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [39:0] DivBase = 40'h00_0200_5000;
  localparam logic [39:0] DivSpan = 40'h00_0000_1000;

  // Where a decoded request goes
  typedef enum logic [1:0] {
    TGT_SRAM,
    TGT_DIV,
    TGT_ERR
  } mem_target_e;

endpackage

//--- mem_chip_sram_bank.sv
////////////////////////////////////////////////////////////////////////////
// Local SRAM bank: word addressed, byte-select writes, combinational read
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mem_chip_sram_bank
  import mem_chip_bus_pkg::*;
  import mem_chip_addr_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    we_i,
  input  logic [SramIdxWidth-1:0] idx_i,
  input  logic [DataWidth-1:0]    wdata_i,
  input  logic [SelWidth-1:0]     sel_i,
  output logic [DataWidth-1:0]    rdata_o
);

  logic [DataWidth-1:0] mem_q [SramWords];

  ////////////////////////////////////////////////////////////////////////////
  // Write port
  ////////////////////////////////////////////////////////////////////////////

  // Only the selected byte lanes change
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      for (int b = 0; b < SelWidth; b++) begin
        if (sel_i[b]) begin
          mem_q[idx_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read port
  ////////////////////////////////////////////////////////////////////////////

  // Full word is returned, byte selects only mask writes
  assign rdata_o = mem_q[idx_i];

endmodule

//--- mem_chip_div_regs.sv
////////////////////////////////////////////////////////////////////////////
// Clock division settings: five 8-bit registers with bus access,
// exported as one packed vector for the clock generator
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mem_chip_div_regs
  import mem_chip_bus_pkg::*;
  import mem_chip_addr_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        we_i,
  input  logic [SramIdxWidth-1:0]     idx_i,
  input  logic [DataWidth-1:0]        wdata_i,
  input  logic                        sel0_i,
  output logic [DataWidth-1:0]        rdata_o,
  output logic                        bad_idx_o,
  output logic [NumDivs*DivWidth-1:0] clk_div_cfg_o
);

  logic [DivWidth-1:0] div_q [NumDivs];

  assign bad_idx_o = (idx_i >= SramIdxWidth'(NumDivs));

  // Setting lives in the low byte, other lanes are ignored
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int k = 0; k < NumDivs; k++) begin
        div_q[k] <= DivDefaults[k*DivWidth +: DivWidth];
      end
    end else if (we_i && sel0_i) begin
      for (int k = 0; k < NumDivs; k++) begin
        if (idx_i == SramIdxWidth'(k)) begin
          div_q[k] <= wdata_i[DivWidth-1:0];
        end
      end
    end
  end

  // Zero-extended readback
  always_comb begin
    rdata_o = '0;
    for (int k = 0; k < NumDivs; k++) begin
      if (idx_i == SramIdxWidth'(k)) begin
        rdata_o = DataWidth'(div_q[k]);
      end
    end
  end

  always_comb begin
    for (int k = 0; k < NumDivs; k++) begin
      clk_div_cfg_o[k*DivWidth +: DivWidth] = div_q[k];
    end
  end

endmodule

//--- mem_chip_decode_stage.sv
////////////////////////////////////////////////////////////////////////////
// First pipeline stage: accepts one Wishbone classic cycle at a time,
// matches the captured chip identifier and the address map, and
// registers the decoded request for the target stage
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mem_chip_decode_stage
  import mem_chip_bus_pkg::*;
  import mem_chip_addr_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic [ChipIdWidth-1:0]  chip_id_i,
  input  logic                    wb_cyc_i,
  input  logic                    wb_stb_i,
  input  logic                    wb_we_i,
  input  logic [AddrWidth-1:0]    wb_adr_i,
  input  logic [DataWidth-1:0]    wb_dat_i,
  input  logic [SelWidth-1:0]     wb_sel_i,
  input  logic                    resp_done_i,
  output logic                    req_valid_o,
  output mem_target_e             req_target_o,
  output logic [SramIdxWidth-1:0] req_idx_o,
  output logic                    req_we_o,
  output logic [DataWidth-1:0]    req_wdata_o,
  output logic [SelWidth-1:0]     req_sel_o
);

  logic [ChipIdWidth-1:0]  chip_id_q;
  logic                    busy_q;
  logic                    accept;
  logic [OffsetWidth-1:0]  offset;
  logic [OffsetWidth-1:0]  sram_off;
  logic [OffsetWidth-1:0]  div_off;
  mem_target_e             target_d;
  logic [SramIdxWidth-1:0] idx_d;

  // Identifier follows the pins while reset is held
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      chip_id_q <= chip_id_i;
    end
  end

  assign accept = wb_cyc_i && wb_stb_i && !busy_q;

  always_comb begin
    offset   = wb_adr_i[OffsetWidth-1:0];
    sram_off = offset - SramBase;
    div_off  = offset - DivBase;
    target_d = TGT_ERR;
    idx_d    = '0;
    if (wb_adr_i[AddrWidth-1 -: ChipIdWidth] == chip_id_q) begin
      if (offset >= SramBase && offset < SramBase + SramSpan) begin
        target_d = TGT_SRAM;
        idx_d    = sram_off[SramIdxWidth+1:2];
      end else if (offset >= DivBase && offset < DivBase + DivSpan &&
                   (div_off >> (SramIdxWidth + 2)) == '0) begin
        target_d = TGT_DIV;
        idx_d    = div_off[SramIdxWidth+1:2];
      end
    end
  end

  // Busy spans the cycle of the response so the held strobe is not taken twice
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      busy_q      <= 1'b0;
      req_valid_o <= 1'b0;
    end else begin
      req_valid_o <= accept;
      if (accept) begin
        busy_q <= 1'b1;
      end else if (resp_done_i) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_target_o <= target_d;
      req_idx_o    <= idx_d;
      req_we_o     <= wb_we_i;
      req_wdata_o  <= wb_dat_i;
      req_sel_o    <= wb_sel_i;
    end
  end

  a_single_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_valid_o |=> !req_valid_o);

endmodule

//--- mem_chip_target_stage.sv
////////////////////////////////////////////////////////////////////////////
// Second pipeline stage: serves the decoded request from the SRAM or the
// divider registers and registers the Wishbone acknowledge or error
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mem_chip_target_stage
  import mem_chip_bus_pkg::*;
  import mem_chip_addr_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        req_valid_i,
  input  mem_target_e                 req_target_i,
  input  logic [SramIdxWidth-1:0]     req_idx_i,
  input  logic                        req_we_i,
  input  logic [DataWidth-1:0]        req_wdata_i,
  input  logic [SelWidth-1:0]         req_sel_i,
  output logic [DataWidth-1:0]        wb_dat_o,
  output logic                        wb_ack_o,
  output logic                        wb_err_o,
  output logic [NumDivs*DivWidth-1:0] clk_div_cfg_o
);

  logic                 sram_we;
  logic                 div_we;
  logic [DataWidth-1:0] sram_rdata;
  logic [DataWidth-1:0] div_rdata;
  logic                 div_bad_idx;
  logic [DataWidth-1:0] rdata_mux;
  logic                 resp_err;

  assign sram_we = req_valid_i && req_we_i && (req_target_i == TGT_SRAM);
  assign div_we  = req_valid_i && req_we_i && (req_target_i == TGT_DIV);

  mem_chip_sram_bank i_sram (
    .clk_i  (clk_i),
    .we_i   (sram_we),
    .idx_i  (req_idx_i),
    .wdata_i(req_wdata_i),
    .sel_i  (req_sel_i),
    .rdata_o(sram_rdata)
  );

  mem_chip_div_regs i_div_regs (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .we_i         (div_we),
    .idx_i        (req_idx_i),
    .wdata_i      (req_wdata_i),
    .sel0_i       (req_sel_i[0]),
    .rdata_o      (div_rdata),
    .bad_idx_o    (div_bad_idx),
    .clk_div_cfg_o(clk_div_cfg_o)
  );

  always_comb begin
    case (req_target_i)
      TGT_SRAM: rdata_mux = sram_rdata;
      TGT_DIV:  rdata_mux = div_rdata;
      default:  rdata_mux = '0;
    endcase
  end

  // Missing divider registers answer with an error as well
  assign resp_err = (req_target_i == TGT_ERR) || (req_target_i == TGT_DIV && div_bad_idx);

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      wb_ack_o <= 1'b0;
      wb_err_o <= 1'b0;
    end else begin
      wb_ack_o <= req_valid_i && !resp_err;
      wb_err_o <= req_valid_i && resp_err;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      wb_dat_o <= rdata_mux;
    end
  end

  // Every request gets exactly one kind of response on the next cycle
  a_resp_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_valid_i |=> $onehot({wb_ack_o, wb_err_o}));

  // A response lasts a single cycle
  a_resp_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wb_ack_o || wb_err_o) |=> !(wb_ack_o || wb_err_o));

endmodule

//--- mem_chip.sv
////////////////////////////////////////////////////////////////////////////
// Memory chip top level: Wishbone classic slave in front of the local
// SRAM and clock divider registers, two-stage decode and serve pipeline
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mem_chip
  import mem_chip_bus_pkg::*;
  import mem_chip_addr_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic [ChipIdWidth-1:0]      chip_id_i,
  input  logic                        wb_cyc_i,
  input  logic                        wb_stb_i,
  input  logic                        wb_we_i,
  input  logic [AddrWidth-1:0]        wb_adr_i,
  input  logic [DataWidth-1:0]        wb_dat_i,
  input  logic [SelWidth-1:0]         wb_sel_i,
  output logic [DataWidth-1:0]        wb_dat_o,
  output logic                        wb_ack_o,
  output logic                        wb_err_o,
  output logic [NumDivs*DivWidth-1:0] clk_div_cfg_o
);

  logic                    req_valid;
  mem_target_e             req_target;
  logic [SramIdxWidth-1:0] req_idx;
  logic                    req_we;
  logic [DataWidth-1:0]    req_wdata;
  logic [SelWidth-1:0]     req_sel;
  logic                    resp_done;

  // Either response ends the Wishbone cycle
  assign resp_done = wb_ack_o | wb_err_o;

  mem_chip_decode_stage i_decode (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .chip_id_i   (chip_id_i),
    .wb_cyc_i    (wb_cyc_i),
    .wb_stb_i    (wb_stb_i),
    .wb_we_i     (wb_we_i),
    .wb_adr_i    (wb_adr_i),
    .wb_dat_i    (wb_dat_i),
    .wb_sel_i    (wb_sel_i),
    .resp_done_i (resp_done),
    .req_valid_o (req_valid),
    .req_target_o(req_target),
    .req_idx_o   (req_idx),
    .req_we_o    (req_we),
    .req_wdata_o (req_wdata),
    .req_sel_o   (req_sel)
  );

  mem_chip_target_stage i_target (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_valid_i  (req_valid),
    .req_target_i (req_target),
    .req_idx_i    (req_idx),
    .req_we_i     (req_we),
    .req_wdata_i  (req_wdata),
    .req_sel_i    (req_sel),
    .wb_dat_o     (wb_dat_o),
    .wb_ack_o     (wb_ack_o),
    .wb_err_o     (wb_err_o),
    .clk_div_cfg_o(clk_div_cfg_o)
  );

endmodule

//--- tb_mem_chip.sv
////////////////////////////////////////////////////////////////////////////
// Self-checking testbench for the memory chip: runs Wishbone transfers,
// predicts each response with a reference model and compares per transfer
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_mem_chip
  import mem_chip_bus_pkg::*;
  import mem_chip_addr_pkg::*;
();

  localparam int SramTests = 64;
  localparam int NumTransfers = 5 + 3 * SramTests + 6 + 4 + 4;
  localparam int CycleLimit = 20 * NumTransfers + 50;
  localparam int ExpLatency = 2;
  localparam int MaxRec = 256;
  localparam logic [7:0] OwnId = 8'h03;
  localparam logic [7:0] OtherId = 8'h5A;
  localparam logic [39:0] SramBytes = 40'h400;

  logic                        clk_i;
  logic                        rst_ni;
  logic [ChipIdWidth-1:0]      chip_id_i;
  logic                        wb_cyc_i;
  logic                        wb_stb_i;
  logic                        wb_we_i;
  logic [AddrWidth-1:0]        wb_adr_i;
  logic [DataWidth-1:0]        wb_dat_i;
  logic [SelWidth-1:0]         wb_sel_i;
  logic [DataWidth-1:0]        wb_dat_o;
  logic                        wb_ack_o;
  logic                        wb_err_o;
  logic [NumDivs*DivWidth-1:0] clk_div_cfg_o;

  // Reference model state and stimulus source
  logic [31:0] ref_sram [256];
  logic [7:0]  ref_div [5];
  logic [7:0]  idx_list [SramTests];
  logic [31:0] lfsr_q;
  int          cycle_cnt;

  // One record per transfer, filled by the driver and read by the checker
  string       rec_name [MaxRec];
  int          rec_lat [MaxRec];
  logic        rec_both [MaxRec];
  logic        rec_chk_dat [MaxRec];
  logic        rec_exp_err [MaxRec];
  logic        rec_act_err [MaxRec];
  logic [31:0] rec_exp_dat [MaxRec];
  logic [31:0] rec_act_dat [MaxRec];
  logic [39:0] rec_exp_cfg [MaxRec];
  logic [39:0] rec_act_cfg [MaxRec];
  int          n_rec;
  int          n_checked;
  int          n_fail;

  mem_chip i_dut (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .chip_id_i    (chip_id_i),
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .wb_we_i      (wb_we_i),
    .wb_adr_i     (wb_adr_i),
    .wb_dat_i     (wb_dat_i),
    .wb_sel_i     (wb_sel_i),
    .wb_dat_o     (wb_dat_o),
    .wb_ack_o     (wb_ack_o),
    .wb_err_o     (wb_err_o),
    .clk_div_cfg_o(clk_div_cfg_o)
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever begin
      #50 clk_i = ~clk_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers and reference model
  ////////////////////////////////////////////////////////////////////////////

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      r = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  function automatic logic [47:0] sram_addr(input logic [7:0] id, input logic [7:0] idx);
    return {id, SramBase + {30'd0, idx, 2'b00}};
  endfunction

  function automatic logic [47:0] div_addr(input logic [7:0] id, input logic [7:0] idx);
    return {id, DivBase + {30'd0, idx, 2'b00}};
  endfunction

  function automatic logic [39:0] ref_cfg();
    return {ref_div[4], ref_div[3], ref_div[2], ref_div[1], ref_div[0]};
  endfunction

  // Applies one transfer to the model and predicts data and error flag
  function automatic void ref_access(input logic we, input logic [47:0] adr,
                                     input logic [31:0] dat, input logic [3:0] sel,
                                     output logic [31:0] exp_dat, output logic exp_err);
    logic [39:0] off;
    logic [39:0] rel;
    exp_dat = '0;
    exp_err = 1'b1;
    off = adr[39:0];
    if (adr[47:40] != OwnId) begin
      return;
    end
    if (off >= SramBase && off < SramBase + SramBytes) begin
      rel = off - SramBase;
      exp_err = 1'b0;
      exp_dat = ref_sram[rel[9:2]];
      for (int b = 0; b < 4; b++) begin
        if (we && sel[b]) begin
          ref_sram[rel[9:2]][8*b +: 8] = dat[8*b +: 8];
        end
      end
    end else if (off >= DivBase && off < DivBase + DivSpan) begin
      rel = off - DivBase;
      // Five registers, four bytes apart
      if (rel < 40'd20) begin
        exp_err = 1'b0;
        exp_dat = {24'd0, ref_div[rel[4:2]]};
        if (we && sel[0]) begin
          ref_div[rel[4:2]] = dat[7:0];
        end
      end
    end
  endfunction

  task automatic run_transfer(input string name, input logic we, input logic [47:0] adr,
                              input logic [31:0] dat, input logic [3:0] sel);
    logic [31:0] exp_dat;
    logic        exp_err;
    int          lat;
    logic        both;
    lat = 0;
    both = 1'b0;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i = we;
    wb_adr_i = adr;
    wb_dat_i = dat;
    wb_sel_i = sel;
    do begin
      @(posedge clk_i);
      #1;
      lat++;
      if (wb_ack_o && wb_err_o) begin
        both = 1'b1;
      end
    end while (!wb_ack_o && !wb_err_o);
    rec_name[n_rec] = name;
    rec_lat[n_rec] = lat;
    rec_both[n_rec] = both;
    rec_act_err[n_rec] = wb_err_o;
    rec_act_dat[n_rec] = wb_dat_o;
    rec_act_cfg[n_rec] = clk_div_cfg_o;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i = 1'b0;
    ref_access(we, adr, dat, sel, exp_dat, exp_err);
    rec_exp_err[n_rec] = exp_err;
    rec_exp_dat[n_rec] = exp_dat;
    rec_chk_dat[n_rec] = !we && !exp_err;
    rec_exp_cfg[n_rec] = ref_cfg();
    n_rec++;
    // Idle cycle before the next strobe
    @(posedge clk_i);
    #1;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Checking
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_record(input int i);
    logic bad;
    bad = 1'b0;
    if (rec_both[i]) begin
      $display("%s: ack and err were high at the same time", rec_name[i]);
      bad = 1'b1;
    end
    if (rec_lat[i] != ExpLatency) begin
      $display("%s: response came %0d cycles after the strobe instead of %0d",
               rec_name[i], rec_lat[i], ExpLatency);
      bad = 1'b1;
    end
    if (rec_act_err[i] !== rec_exp_err[i]) begin
      $display("ERR %s err expected %0d actual %0d", rec_name[i], rec_exp_err[i],
               rec_act_err[i]);
      bad = 1'b1;
    end
    if (rec_chk_dat[i] && rec_act_dat[i] !== rec_exp_dat[i]) begin
      $display("ERR %s data expected 0x%08h actual 0x%08h", rec_name[i], rec_exp_dat[i],
               rec_act_dat[i]);
      bad = 1'b1;
    end
    if (rec_act_cfg[i] !== rec_exp_cfg[i]) begin
      $display("ERR %s clk_div_cfg expected 0x%010h actual 0x%010h", rec_name[i],
               rec_exp_cfg[i], rec_act_cfg[i]);
      bad = 1'b1;
    end
    if (bad) begin
      n_fail++;
      $display("test %s failed", rec_name[i]);
    end else begin
      $display("test %s ok", rec_name[i]);
    end
  endtask

  initial begin : compare_results
    forever begin
      wait (n_checked < n_rec);
      check_record(n_checked);
      n_checked++;
    end
  end

  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < CycleLimit) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("Run stopped after %0d cycles, transfers did not complete", cycle_cnt);
    $display("=== FAIL ===");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin : run_tests
    logic [31:0] d;
    logic [3:0]  s;
    rst_ni = 1'b0;
    chip_id_i = OwnId;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    wb_sel_i = '0;
    lfsr_q = 32'he682_9304;
    n_rec = 0;
    n_checked = 0;
    n_fail = 0;
    ref_div[0] = 8'd4;
    for (int k = 1; k < 5; k++) begin
      ref_div[k] = 8'd1;
    end
    repeat (3) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    // Pins change after reset, the captured identifier must stay
    chip_id_i = OtherId;

    for (int k = 0; k < 5; k++) begin
      run_transfer($sformatf("div_default_%0d", k), 1'b0, div_addr(OwnId, 8'(k)), '0, 4'hF);
    end

    for (int i = 0; i < SramTests; i++) begin
      idx_list[i] = 8'(rand_bits(8));
      d = rand_bits(32);
      run_transfer($sformatf("sram_fill_%0d", i), 1'b1, sram_addr(OwnId, idx_list[i]), d,
                   4'hF);
    end
    for (int i = 0; i < SramTests; i++) begin
      d = rand_bits(32);
      s = 4'(rand_bits(4));
      run_transfer($sformatf("sram_merge_%0d", i), 1'b1, sram_addr(OwnId, idx_list[i]), d, s);
    end
    for (int i = 0; i < SramTests; i++) begin
      run_transfer($sformatf("sram_read_%0d", i), 1'b0, sram_addr(OwnId, idx_list[i]), '0,
                   4'hF);
    end

    run_transfer("div_wr_sel0", 1'b1, div_addr(OwnId, 8'd2), 32'hABCD_EF37, 4'h1);
    run_transfer("div_rd_sel0", 1'b0, div_addr(OwnId, 8'd2), '0, 4'hF);
    run_transfer("div_wr_nosel0", 1'b1, div_addr(OwnId, 8'd2), 32'h0000_0099, 4'hE);
    run_transfer("div_rd_nosel0", 1'b0, div_addr(OwnId, 8'd2), '0, 4'hF);
    run_transfer("div_wr_last", 1'b1, div_addr(OwnId, 8'd4), 32'h0000_0010, 4'hF);
    run_transfer("div_rd_last", 1'b0, div_addr(OwnId, 8'd4), '0, 4'hF);

    run_transfer("other_id_sram_wr", 1'b1, sram_addr(OtherId, idx_list[0]), 32'hDEAD_BEEF,
                 4'hF);
    run_transfer("own_id_sram_rd", 1'b0, sram_addr(OwnId, idx_list[0]), '0, 4'hF);
    run_transfer("other_id_div_wr", 1'b1, div_addr(OtherId, 8'd1), 32'h0000_0007, 4'hF);
    run_transfer("own_id_div_rd", 1'b0, div_addr(OwnId, 8'd1), '0, 4'hF);

    run_transfer("unmapped_rd", 1'b0, {OwnId, 40'h00_1000_0000}, '0, 4'hF);
    run_transfer("sram_above_rd", 1'b0, {OwnId, SramBase + SramBytes}, '0, 4'hF);
    run_transfer("div_idx5_rd", 1'b0, div_addr(OwnId, 8'd5), '0, 4'hF);
    run_transfer("div_idx5_wr", 1'b1, div_addr(OwnId, 8'd5), 32'h0000_0003, 4'hF);

    wait (n_checked == n_rec);
    $display("%0d tests, %0d passed, %0d failed", n_rec, n_rec - n_fail, n_fail);
    if (n_fail == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- mem_chip.f
mem_chip_bus_pkg.sv
mem_chip_addr_pkg.sv
mem_chip_sram_bank.sv
mem_chip_div_regs.sv
mem_chip_decode_stage.sv
mem_chip_target_stage.sv
mem_chip.sv
tb_mem_chip.sv

//--- Makefile
# Verilator build and run of the memory chip testbench

TOP := tb_mem_chip
OBJ := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -f mem_chip.f --top-module $(TOP) -Mdir $(OBJ)
	@out="$$(./$(OBJ)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^=== PASS ===$$'

clean:
	rm -rf $(OBJ)
